/* Makefile */
# Verilator flow for the packet filter

VERILATOR  ?= verilator
TOP        ?= pfilt_tb
RTL_TOP    ?= pfilt_top
FILELIST   ?= pfilt_top.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* pfilt_top.f */
+incdir+verilog
verilog/pfilt_pkg.sv
verilog/pfilt_apb_regs.sv
verilog/pfilt_snooper.sv
verilog/pfilt_core.sv
verilog/pfilt_forwarder.sv
verilog/pfilt_top.sv
tests/pfilt_tb.sv

/* tests/pfilt_tb.sv */
`include "pfilt_defs.svh"

module pfilt_tb;

    localparam int CLK_HALF = 4;
    localparam int WAIT_MAX = 400;     // Bound on every wait loop

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic [`PF_APB_AW-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  in_valid;
    logic                  in_ready;
    logic [`PF_DATA_W-1:0] in_data;
    logic [`PF_KEEP_W-1:0] in_keep;
    logic                  in_last;
    logic                  out_valid;
    logic [`PF_DATA_W-1:0] out_data;
    logic [`PF_KEEP_W-1:0] out_keep;
    logic                  out_last;
    logic                  out_ready = 1'b0;

    logic [31:0] lcg_state = 32'h8065;
    bit          rand_ready = 1'b1;    // 0 holds out_ready low
    logic [36:0] exp_q [$];            // {last, keep, data} per beat
    int          exp_rd;               // Monitor's read index
    int          errors, beat_errors, hold_errors, err_mark;
    int          tests_run, tests_failed, pkt_seq;
    int          acc_exp, rej_exp, drop_exp;
    string       test_name = "reset";

    pfilt_top i_pfilt_top (
        .clk, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .in_valid, .in_ready, .in_data, .in_keep, .in_last,
        .out_valid, .out_data, .out_keep, .out_last, .out_ready
    );

    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Sink side back-pressure
    always @(negedge clk) begin
        logic [31:0] r;
        r = lcg_next();
        out_ready <= rand_ready && r[16];
    end

    // Compare each transferred beat with the model's queue
    always @(posedge clk) begin
        logic [36:0] want;
        if (arst_n && out_valid && out_ready) begin
            if (exp_rd >= exp_q.size()) begin
                beat_errors++;
                $display("Output beat %h arrived with none expected in test %s",
                         out_data, test_name);
            end else begin
                want = exp_q[exp_rd];
                exp_rd++;
                assert ({out_last, out_keep, out_data} === want)
                else begin
                    beat_errors++;
                    $display("[FAIL] %s out beat: expected %h, actual %h", test_name,
                             want, {out_last, out_keep, out_data});
                end
            end
        end
    end

    // Stalled beat must hold
    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable({out_data, out_keep, out_last}))
    else begin
        hold_errors++;
        $display("Output beat changed while stalled in test %s", test_name);
    end

    function automatic int total_errors();
        return errors + beat_errors + hold_errors;
    endfunction

    // Filter rule of the accept program
    function automatic bit rule_accepts(input logic [31:0] word0);
        return word0[15:0] == 16'h0800;
    endfunction

    function automatic logic [31:0] enc_cmp(input logic [5:0] idx, input logic upper,
                                            input logic [15:0] value);
        return {4'h1, idx, upper, 5'b0, value};
    endfunction

    function automatic logic [31:0] enc_jump(input logic [3:0] op, input logic [3:0] target);
        return {op, 24'h0, target};
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout while waiting for %s in test %s", what, test_name);
    endtask

    // One APB transfer, setup then access
    task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int n;
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!pready && n < WAIT_MAX);
        if (!pready)
            report_timeout("pready");
        rdata = prdata;    // Values of the access phase
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] v;
        logic        e;
        apb_access(addr, 1'b1, data, v, e);
    endtask

    task automatic read_expect(input string what, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] v;
        logic        e;
        apb_access(addr, 1'b0, 32'h0, v, e);
        expect_eq(what, exp, v);
    endtask

    // Poll a register until it reaches the target
    task automatic wait_reg(input string what, input logic [7:0] addr, input logic [31:0] target);
        logic [31:0] v;
        logic        e;
        int          n;
        n = 0;
        do begin
            apb_access(addr, 1'b0, 32'h0, v, e);
            n++;
        end while (v !== target && n < WAIT_MAX);
        expect_eq(what, target, v);
    endtask

    task automatic load_program(input logic [31:0] w0, input logic [31:0] w1,
                                input logic [31:0] w2, input logic [31:0] w3);
        apb_write(`PF_REG_INST_ADDR, 32'h0);
        apb_write(`PF_REG_INST_DATA, w0);  // Address steps by itself
        apb_write(`PF_REG_INST_DATA, w1);
        apb_write(`PF_REG_INST_DATA, w2);
        apb_write(`PF_REG_INST_DATA, w3);
    endtask

    // Full keeps up to a short tail; taken=0 when the packet must never come out
    task automatic send_packet(input logic [31:0] word0, input int n_words,
                               input logic [3:0] tail_keep, input bit taken);
        logic [31:0] w;
        pkt_seq++;
        for (int i = 0; i < n_words; i++) begin
            @(negedge clk);
            w = (i == 0) ? word0 : 32'hc0de_0000 + (pkt_seq << 8) + i;
            in_valid = 1'b1;
            in_ready = 1'b1;
            in_data  = w;
            in_last  = i == n_words - 1;
            in_keep  = in_last ? tail_keep : 4'hf;
            if (taken && rule_accepts(word0))
                exp_q.push_back({in_last, in_keep, w});
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_ready = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_rd < exp_q.size() && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (exp_rd < exp_q.size())
            report_timeout("expected output beats");
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = total_errors();
    endtask

    task automatic end_test();
        int n;
        n = total_errors() - err_mark;
        tests_run++;
        if (n == 0) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, n);
        end
    endtask

    task automatic test_regs();
        logic [31:0] v;
        logic        e;
        begin_test("registers");
        read_expect("DROPPED after reset", `PF_REG_DROPPED, 32'h0);
        read_expect("ACCEPTED after reset", `PF_REG_ACCEPTED, 32'h0);
        read_expect("REJECTED after reset", `PF_REG_REJECTED, 32'h0);
        apb_write(`PF_REG_CTRL, 32'h1);
        read_expect("CTRL", `PF_REG_CTRL, 32'h1);
        apb_access(8'h20, 1'b0, 32'h0, v, e);  // Hole in the map
        expect_eq("unmapped pslverr", 32'h1, {31'b0, e});
        apb_access(`PF_REG_CTRL, 1'b0, 32'h0, v, e);
        expect_eq("mapped pslverr", 32'h0, {31'b0, e});
        // Accept on low half of word 0 == 0x0800
        load_program(enc_cmp(6'd0, 1'b0, 16'h0800), enc_jump(4'h3, 4'd3),
                     enc_jump(4'h5, 4'd0), 32'h0);
        read_expect("INST_ADDR", `PF_REG_INST_ADDR, 32'h4);
        end_test();
    endtask

    task automatic test_accept();
        begin_test("accept");
        rand_ready = 1'b1;
        send_packet(32'h1234_0800, 4, 4'hf, 1'b1);
        wait_drain();
        acc_exp++;
        read_expect("ACCEPTED", `PF_REG_ACCEPTED, acc_exp);
        send_packet(32'habcd_0800, 1, 4'h1, 1'b1);    // Single byte
        wait_drain();
        acc_exp++;
        read_expect("ACCEPTED", `PF_REG_ACCEPTED, acc_exp);
        send_packet(32'h0000_0800, 7, 4'h7, 1'b1);
        wait_drain();
        acc_exp++;
        read_expect("ACCEPTED", `PF_REG_ACCEPTED, acc_exp);
        end_test();
    endtask

    task automatic test_reject();
        begin_test("reject");
        send_packet(32'h0800_0806, 3, 4'h3, 1'b1);    // Match sits in the wrong half
        rej_exp++;
        wait_reg("REJECTED", `PF_REG_REJECTED, rej_exp);
        read_expect("ACCEPTED", `PF_REG_ACCEPTED, acc_exp);
        end_test();
    endtask

    task automatic test_drop();
        int n;
        begin_test("drop");
        rand_ready = 1'b0;
        send_packet(32'h5555_0800, 3, 4'hf, 1'b1);
        n = 0;
        while (!out_valid && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid)
            report_timeout("stalled first beat");
        send_packet(32'h6666_0800, 2, 4'hf, 1'b0);    // Core busy, must vanish
        drop_exp++;
        acc_exp++;
        read_expect("DROPPED", `PF_REG_DROPPED, drop_exp);
        read_expect("ACCEPTED", `PF_REG_ACCEPTED, acc_exp);
        rand_ready = 1'b1;
        wait_drain();
        read_expect("DROPPED after drain", `PF_REG_DROPPED, drop_exp);
        end_test();
    endtask

    task automatic test_runaway();
        begin_test("runaway");
        load_program(enc_jump(4'h4, 4'd0), 32'h0, 32'h0, 32'h0);    // Jump to self
        send_packet(32'h7777_0800, 2, 4'hf, 1'b0);
        // Still looping, far short of the step limit
        read_expect("REJECTED before step limit", `PF_REG_REJECTED, rej_exp);
        rej_exp++;
        wait_reg("REJECTED", `PF_REG_REJECTED, rej_exp);
        read_expect("ACCEPTED", `PF_REG_ACCEPTED, acc_exp);
        end_test();
    endtask

    task automatic test_stop();
        begin_test("stop");
        load_program(enc_cmp(6'd0, 1'b0, 16'h0800), enc_jump(4'h3, 4'd3),
                     enc_jump(4'h5, 4'd0), 32'h0);
        apb_write(`PF_REG_CTRL, 32'h0);
        read_expect("CTRL", `PF_REG_CTRL, 32'h0);
        send_packet(32'h8888_0800, 3, 4'hf, 1'b0);
        send_packet(32'h9999_0801, 2, 4'h1, 1'b0);
        read_expect("DROPPED", `PF_REG_DROPPED, drop_exp);
        read_expect("ACCEPTED", `PF_REG_ACCEPTED, acc_exp);
        read_expect("REJECTED", `PF_REG_REJECTED, rej_exp);
        end_test();
    endtask

    initial begin
        arst_n   = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        in_valid = 1'b0;
        in_ready = 1'b0;
        in_data  = '0;
        in_keep  = '0;
        in_last  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_regs();
        test_accept();
        test_reject();
        test_drop();
        test_runaway();
        test_stop();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/pfilt_apb_regs.sv */
`include "pfilt_defs.svh"

module pfilt_apb_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`PF_APB_AW-1:0]  paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   drop_pulse,
    input  logic                   acc_pulse,
    input  logic                   rej_pulse,
    output logic                   run,
    output logic                   prog_wr_en,
    output logic [`PF_PROG_AW-1:0] prog_wr_addr,
    output pfilt_pkg::pf_inst_u    prog_wr_data
);

    logic                   wr_acc;     // Write in access phase
    logic                   addr_hit;
    logic [`PF_PROG_AW-1:0] inst_addr;
    logic [`PF_CNT_W-1:0]   cnt_drop;
    logic [`PF_CNT_W-1:0]   cnt_acc;
    logic [`PF_CNT_W-1:0]   cnt_rej;

    // Counters stick at all ones
    function automatic logic [`PF_CNT_W-1:0] sat_inc(input logic [`PF_CNT_W-1:0] c,
                                                     input logic inc);
        return (inc && c != '1) ? c + 1'b1 : c;
    endfunction

    assign pready = 1'b1;   // No wait states
    assign wr_acc = psel && penable && pwrite;

    // Program load strobe straight off the bus
    assign prog_wr_en   = wr_acc && paddr == `PF_REG_INST_DATA;
    assign prog_wr_addr = inst_addr;
    assign prog_wr_data = pwdata;

    // Read mux and address decode
    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            `PF_REG_CTRL:      prdata[0] = run;
            `PF_REG_DROPPED:   prdata[`PF_CNT_W-1:0] = cnt_drop;
            `PF_REG_ACCEPTED:  prdata[`PF_CNT_W-1:0] = cnt_acc;
            `PF_REG_REJECTED:  prdata[`PF_CNT_W-1:0] = cnt_rej;
            `PF_REG_INST_ADDR: prdata[`PF_PROG_AW-1:0] = inst_addr;
            `PF_REG_INST_DATA: prdata = '0;    // Reads as zero
            default:           addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run       <= 1'b0;
            inst_addr <= '0;
            pslverr   <= 1'b0;
            cnt_drop  <= '0;
            cnt_acc   <= '0;
            cnt_rej   <= '0;
        end else begin
            pslverr  <= psel && !penable && !addr_hit;   // Decoded in setup, shown in access
            cnt_drop <= sat_inc(cnt_drop, drop_pulse);
            cnt_acc  <= sat_inc(cnt_acc, acc_pulse);
            cnt_rej  <= sat_inc(cnt_rej, rej_pulse);
            if (wr_acc && paddr == `PF_REG_CTRL)
                run <= pwdata[0];
            if (wr_acc && paddr == `PF_REG_INST_ADDR)
                inst_addr <= pwdata[`PF_PROG_AW-1:0];
            else if (prog_wr_en)
                inst_addr <= inst_addr + 1'b1;  // Next slot for a streamed program
        end
    end

    // Error flag belongs to the access phase of the same transfer
    a_slverr_access: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> psel && penable);

endmodule

/* verilog/pfilt_core.sv */
`include "pfilt_defs.svh"

module pfilt_core (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   run,
    input  logic                   buf_wr_en,
    input  logic [`PF_BUF_AW-1:0]  buf_wr_addr,
    input  logic [`PF_DATA_W-1:0]  buf_wr_data,
    input  logic                   sn_done,
    input  logic [`PF_LEN_W-1:0]   sn_byte_len,
    input  logic                   prog_wr_en,
    input  logic [`PF_PROG_AW-1:0] prog_wr_addr,
    input  pfilt_pkg::pf_inst_u    prog_wr_data,
    input  logic                   buf_rd_en,
    input  logic [`PF_BUF_AW-1:0]  buf_rd_addr,
    input  logic                   fwd_done,
    output logic                   core_idle,
    output logic [`PF_DATA_W-1:0]  buf_rd_data,
    output logic                   fwd_req,
    output logic [`PF_LEN_W-1:0]   fwd_byte_len,
    output logic                   acc_pulse,
    output logic                   rej_pulse
);

    import pfilt_pkg::*;

    localparam int STEP_W = $clog2(`PF_MAX_STEPS + 1);

    localparam logic [1:0] C_IDLE = 2'd0;
    localparam logic [1:0] C_EXEC = 2'd1;   // Fetch and execute
    localparam logic [1:0] C_CMP  = 2'd2;   // Compare, buffer word now valid
    localparam logic [1:0] C_FWD  = 2'd3;   // Packet handed to forwarder

    logic [`PF_DATA_W-1:0]  pkt_mem [`PF_BUF_DEPTH];
    pf_inst_u               prog_mem [`PF_PROG_DEPTH];
    pf_inst_u               inst;
    logic [1:0]             state;
    logic [`PF_PROG_AW-1:0] pc;
    logic                   flag;
    logic [STEP_W-1:0]      steps;
    logic                   rd_en;
    logic [`PF_BUF_AW-1:0]  rd_addr;
    logic [15:0]            cmp_half;

    assign inst      = prog_mem[pc];    // Async fetch
    assign core_idle = state == C_IDLE;
    assign fwd_req   = state == C_FWD;

    // One read port, shared by engine and forwarder
    assign rd_en   = buf_rd_en || state == C_EXEC;
    assign rd_addr = (state == C_FWD) ? buf_rd_addr : inst.cmp.word_idx;

    assign cmp_half = inst.cmp.half ? buf_rd_data[`PF_DATA_W-1:`PF_DATA_W/2]
                                    : buf_rd_data[`PF_DATA_W/2-1:0];

    always_ff @(posedge clk) begin
        if (buf_wr_en)
            pkt_mem[buf_wr_addr] <= buf_wr_data;
        if (rd_en)
            buf_rd_data <= pkt_mem[rd_addr];    // Holds while no read
        if (prog_wr_en)
            prog_mem[prog_wr_addr] <= prog_wr_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= C_IDLE;
            pc           <= '0;
            flag         <= 1'b0;
            steps        <= '0;
            fwd_byte_len <= '0;
            acc_pulse    <= 1'b0;
            rej_pulse    <= 1'b0;
        end else begin
            acc_pulse <= 1'b0;
            rej_pulse <= 1'b0;
            if (!run) begin
                state <= C_IDLE;
            end else begin
                case (state)
                    C_IDLE: begin
                        if (sn_done) begin
                            state        <= C_EXEC;
                            pc           <= '0;
                            flag         <= 1'b0;
                            steps        <= '0;
                            fwd_byte_len <= sn_byte_len;
                        end
                    end
                    C_EXEC: begin
                        steps <= steps + 1'b1;
                        if (steps == STEP_W'(`PF_MAX_STEPS)) begin
                            rej_pulse <= 1'b1;      // Step limit hit
                            state     <= C_IDLE;
                        end else begin
                            case (inst.cmp.op)
                                OP_CMP: state <= C_CMP;
                                OP_JT:  pc <= flag ? inst.jmp.target : pc + 1'b1;
                                OP_JF:  pc <= flag ? pc + 1'b1 : inst.jmp.target;
                                OP_JMP: pc <= inst.jmp.target;
                                OP_ACC: begin
                                    acc_pulse <= 1'b1;
                                    state     <= C_FWD;
                                end
                                default: begin
                                    rej_pulse <= 1'b1;  // OP_REJ and unknown codes
                                    state     <= C_IDLE;
                                end
                            endcase
                        end
                    end
                    C_CMP: begin
                        flag  <= cmp_half == inst.cmp.value;
                        pc    <= pc + 1'b1;
                        state <= C_EXEC;
                    end
                    default: begin
                        if (fwd_done)
                            state <= C_IDLE;    // Buffer free again
                    end
                endcase
            end
        end
    end

    a_one_verdict: assert property (@(posedge clk) disable iff (!arst_n)
        !(acc_pulse && rej_pulse));

endmodule

/* verilog/pfilt_defs.svh */
`ifndef PFILT_DEFS_SVH
`define PFILT_DEFS_SVH

// Stream word and byte enables
`define PF_DATA_W       32
`define PF_KEEP_W       4

// Packet buffer, one packet at a time
`define PF_BUF_DEPTH    64
`define PF_BUF_AW       6

// Program memory
`define PF_PROG_DEPTH   16
`define PF_PROG_AW      4

`define PF_LEN_W        9       // Byte length, up to 256
`define PF_MAX_STEPS    64      // Runaway guard
`define PF_CNT_W        16      // Event counters
`define PF_APB_AW       8

// Register map
`define PF_REG_CTRL      8'h00  // Bit 0 start
`define PF_REG_DROPPED   8'h04
`define PF_REG_ACCEPTED  8'h08
`define PF_REG_REJECTED  8'h0C
`define PF_REG_INST_ADDR 8'h10
`define PF_REG_INST_DATA 8'h14  // Write-only, bumps INST_ADDR

`endif

/* verilog/pfilt_forwarder.sv */
`include "pfilt_defs.svh"

module pfilt_forwarder (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  run,
    input  logic                  fwd_req,
    input  logic [`PF_LEN_W-1:0]  fwd_byte_len,
    input  logic [`PF_DATA_W-1:0] buf_rd_data,
    input  logic                  out_ready,
    output logic                  buf_rd_en,
    output logic [`PF_BUF_AW-1:0] buf_rd_addr,
    output logic                  out_valid,
    output logic [`PF_DATA_W-1:0] out_data,
    output logic [`PF_KEEP_W-1:0] out_keep,
    output logic                  out_last,
    output logic                  fwd_done
);

    localparam int CNT_W = `PF_BUF_AW + 1;  // Counts up to a full buffer
    localparam int REM_W = $clog2(`PF_KEEP_W);

    logic             active;
    logic [CNT_W-1:0] rd_idx;       // Words read so far
    logic [CNT_W-1:0] n_words;
    logic [REM_W-1:0] rem;
    logic [`PF_KEEP_W-1:0] last_keep;
    logic             xfer;

    assign n_words   = CNT_W'((fwd_byte_len + `PF_KEEP_W - 1) / `PF_KEEP_W);
    assign rem       = fwd_byte_len[REM_W-1:0];
    assign last_keep = (rem == '0) ? '1 : ~({`PF_KEEP_W{1'b1}} << rem);
    assign xfer      = out_valid && out_ready;

    // Read when the output slot is empty or emptying this cycle
    assign buf_rd_en   = active && rd_idx < n_words && (!out_valid || out_ready);
    assign buf_rd_addr = rd_idx[`PF_BUF_AW-1:0];
    assign out_data    = buf_rd_data;   // Buffer read register is the data stage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active    <= 1'b0;
            rd_idx    <= '0;
            out_valid <= 1'b0;
            out_keep  <= '0;
            out_last  <= 1'b0;
            fwd_done  <= 1'b0;
        end else if (!run) begin
            active    <= 1'b0;
            out_valid <= 1'b0;
            fwd_done  <= 1'b0;
        end else begin
            fwd_done <= 1'b0;
            if (!active && fwd_req && !fwd_done) begin
                active <= 1'b1;     // fwd_done guard stops a restart on the old request
                rd_idx <= '0;
            end
            if (buf_rd_en) begin
                rd_idx    <= rd_idx + 1'b1;
                out_valid <= 1'b1;
                out_last  <= rd_idx == n_words - 1'b1;
                out_keep  <= (rd_idx == n_words - 1'b1) ? last_keep : '1;
            end else if (xfer) begin
                out_valid <= 1'b0;
            end
            if (xfer && out_last) begin
                active   <= 1'b0;
                fwd_done <= 1'b1;
            end
        end
    end

    // Relies on the core holding its read register between reads
    a_hold_data: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready && run |=> out_valid && $stable(out_data));

endmodule

/* verilog/pfilt_pkg.sv */
`include "pfilt_defs.svh"

package pfilt_pkg;

    // Unlisted opcodes reject
    typedef enum logic [3:0] {
        OP_REJ = 4'h0,
        OP_CMP = 4'h1,  // Half-word equality, sets flag
        OP_JT  = 4'h2,  // Jump on flag set
        OP_JF  = 4'h3,  // Jump on flag clear
        OP_JMP = 4'h4,
        OP_ACC = 4'h5
    } pf_op_e;

    // Compare view
    typedef struct packed {
        pf_op_e                op;
        logic [`PF_BUF_AW-1:0] word_idx;   // Buffer word to test
        logic                  half;       // 1 selects upper half
        logic [4:0]            reserved;
        logic [15:0]           value;
    } pf_cmp_t;

    // Jump view
    typedef struct packed {
        pf_op_e                          op;
        logic [27-`PF_PROG_AW:0]         reserved;
        logic [`PF_PROG_AW-1:0]          target;
    } pf_jmp_t;

    typedef union packed {
        pf_cmp_t cmp;
        pf_jmp_t jmp;
    } pf_inst_u;

endpackage

/* verilog/pfilt_snooper.sv */
`include "pfilt_defs.svh"

module pfilt_snooper (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  run,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  logic [`PF_DATA_W-1:0] in_data,
    input  logic [`PF_KEEP_W-1:0] in_keep,
    input  logic                  in_last,
    input  logic                  core_idle,
    output logic                  buf_wr_en,
    output logic [`PF_BUF_AW-1:0] buf_wr_addr,
    output logic [`PF_DATA_W-1:0] buf_wr_data,
    output logic                  sn_done,
    output logic [`PF_LEN_W-1:0]  sn_byte_len,
    output logic                  drop_pulse
);

    localparam logic [1:0] S_IDLE    = 2'd0;  // Between packets
    localparam logic [1:0] S_CAPTURE = 2'd1;
    localparam logic [1:0] S_DISCARD = 2'd2;  // Skip to in_last

    logic                 beat;
    logic [1:0]           state;
    logic [`PF_LEN_W-1:0] keep_cnt;
    logic                 can_take;

    assign beat     = in_valid && in_ready;
    assign keep_cnt = `PF_LEN_W'($countones(in_keep));
    // sn_done still pending means the core has not left idle yet
    assign can_take = run && core_idle && !sn_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= S_IDLE;
            buf_wr_en   <= 1'b0;
            buf_wr_addr <= '0;
            sn_done     <= 1'b0;
            sn_byte_len <= '0;
            drop_pulse  <= 1'b0;
        end else begin
            buf_wr_en  <= 1'b0;
            sn_done    <= 1'b0;
            drop_pulse <= 1'b0;
            if (beat) begin
                case (state)
                    S_IDLE: begin
                        if (can_take) begin
                            buf_wr_en   <= 1'b1;
                            buf_wr_addr <= '0;
                            sn_byte_len <= keep_cnt;
                            sn_done     <= in_last;     // Single-beat packet
                            state       <= in_last ? S_IDLE : S_CAPTURE;
                        end else begin
                            drop_pulse <= run;          // Count once, first beat only
                            state      <= in_last ? S_IDLE : S_DISCARD;
                        end
                    end
                    S_CAPTURE: begin
                        if (run) begin
                            buf_wr_en   <= 1'b1;
                            buf_wr_addr <= buf_wr_addr + 1'b1;
                            sn_byte_len <= sn_byte_len + keep_cnt;
                            sn_done     <= in_last;
                        end
                        state <= in_last ? S_IDLE : (run ? S_CAPTURE : S_DISCARD);
                    end
                    default: state <= in_last ? S_IDLE : S_DISCARD;
                endcase
            end else if (!run && state == S_CAPTURE) begin
                state <= S_DISCARD;     // Stopped mid-packet, wait for its end
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (beat)
            buf_wr_data <= in_data;
    end

    // Buffer overflow would wrap onto word 0
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        run && beat && state == S_CAPTURE |->
            buf_wr_addr != `PF_BUF_AW'(`PF_BUF_DEPTH - 1));

endmodule

/* verilog/pfilt_top.sv */
`include "pfilt_defs.svh"

module pfilt_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`PF_APB_AW-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  logic [`PF_DATA_W-1:0] in_data,
    input  logic [`PF_KEEP_W-1:0] in_keep,
    input  logic                  in_last,
    output logic                  out_valid,
    output logic [`PF_DATA_W-1:0] out_data,
    output logic [`PF_KEEP_W-1:0] out_keep,
    output logic                  out_last,
    input  logic                  out_ready
);

    import pfilt_pkg::*;

    logic                   run;
    logic                   prog_wr_en;
    logic [`PF_PROG_AW-1:0] prog_wr_addr;
    pf_inst_u               prog_wr_data;
    logic                   drop_pulse;
    logic                   acc_pulse;
    logic                   rej_pulse;
    // Snooper to core
    logic                   buf_wr_en;
    logic [`PF_BUF_AW-1:0]  buf_wr_addr;
    logic [`PF_DATA_W-1:0]  buf_wr_data;
    logic                   sn_done;
    logic [`PF_LEN_W-1:0]   sn_byte_len;
    logic                   core_idle;
    // Core to forwarder
    logic                   fwd_req;
    logic [`PF_LEN_W-1:0]   fwd_byte_len;
    logic                   buf_rd_en;
    logic [`PF_BUF_AW-1:0]  buf_rd_addr;
    logic [`PF_DATA_W-1:0]  buf_rd_data;
    logic                   fwd_done;

    pfilt_apb_regs i_regs (
        .clk, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .drop_pulse, .acc_pulse, .rej_pulse,
        .run, .prog_wr_en, .prog_wr_addr, .prog_wr_data
    );

    pfilt_snooper i_snooper (
        .clk, .arst_n, .run,
        .in_valid, .in_ready, .in_data, .in_keep, .in_last,
        .core_idle,
        .buf_wr_en, .buf_wr_addr, .buf_wr_data,
        .sn_done, .sn_byte_len, .drop_pulse
    );

    pfilt_core i_core (
        .clk, .arst_n, .run,
        .buf_wr_en, .buf_wr_addr, .buf_wr_data, .sn_done, .sn_byte_len,
        .prog_wr_en, .prog_wr_addr, .prog_wr_data,
        .buf_rd_en, .buf_rd_addr, .fwd_done,
        .core_idle, .buf_rd_data, .fwd_req, .fwd_byte_len,
        .acc_pulse, .rej_pulse
    );

    pfilt_forwarder i_forwarder (
        .clk, .arst_n, .run,
        .fwd_req, .fwd_byte_len, .buf_rd_data, .out_ready,
        .buf_rd_en, .buf_rd_addr,
        .out_valid, .out_data, .out_keep, .out_last, .fwd_done
    );

endmodule
